/* or1420Ci_defines.svh */
`ifndef OR1420_CI_DEFINES_SVH
`define OR1420_CI_DEFINES_SVH

// custom instruction port widths
`define OR1420_WORD_WIDTH 32
`define OR1420_CI_N_WIDTH 8

// one lane per pixel, two pixels per operand
`define OR1420_NUM_LANES 4

// instruction numbers served here
`define OR1420_CI_SWAP_ID 8'd1
`define OR1420_CI_GRAY_ID 8'd9

// luminance weights, they add up to 256 so the sum shifts down by 8
`define OR1420_RED_WEIGHT 8'd54
`define OR1420_GREEN_WEIGHT 8'd183
`define OR1420_BLUE_WEIGHT 8'd19

// top bit of the counter marks the core as ready
`define OR1420_RESET_COUNT_WIDTH 5

`endif

/* ciPkg.sv */
`include "or1420Ci_defines.svh"

package ciPkg;

  // operand and result word
  typedef logic [`OR1420_WORD_WIDTH-1:0] ciWordT;

  // instruction number as seen on the ci port
  typedef logic [`OR1420_CI_N_WIDTH-1:0] ciNumberT;

  // decoded operation carried from dispatch
  typedef enum logic [1:0] {
    CI_OP_NONE = 2'd0,
    CI_OP_SWAP = 2'd1,
    CI_OP_GRAY = 2'd2
  } ciOpT;

endpackage

/* pixelPkg.sv */
package pixelPkg;

  // rgb565 pixel, red in the top bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565T;

  // one grayscale byte
  typedef logic [7:0] grayT;

endpackage

/* pixelLaneIf.sv */
interface pixelLaneIf;
  import pixelPkg::*;

  // pixel towards the lane
  logic   pixelValid;
  rgb565T pixel;

  // gray value back towards the collector
  logic   grayValid;
  grayT   gray;

  modport dispatch (
    output pixelValid,
    output pixel
  );

  modport lane (
    input  pixelValid,
    input  pixel,
    output grayValid,
    output gray
  );

  // collector only sees the result side
  modport collect (
    input grayValid,
    input gray
  );

endinterface

/* resetSequencer.sv */
`include "or1420Ci_defines.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReady
);

  localparam int unsigned countWidth = `OR1420_RESET_COUNT_WIDTH;

  logic [countWidth-1:0] s_resetCountReg;

  // counts up to 16 and then sticks there
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_resetCountReg[countWidth-1]) begin
      s_resetCountReg <= s_resetCountReg + {{(countWidth-1){1'b0}}, 1'b1};
    end
  end

  assign coreReady = s_resetCountReg[countWidth-1];

  // once ready, the core stays out of reset until the pll drops lock
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    coreReady |=> coreReady);

endmodule

/* ciDispatch.sv */
`include "or1420Ci_defines.svh"

module ciDispatch (
  input  logic                s_systemClock,
  input  logic                coreReady,
  input  logic                ciStart,
  input  ciPkg::ciNumberT     ciN,
  input  ciPkg::ciWordT       ciDataA,
  input  ciPkg::ciWordT       ciDataB,
  pixelLaneIf.dispatch        lanes [`OR1420_NUM_LANES],
  output logic                swapValid,
  output ciPkg::ciWordT       swapWord
);
  import ciPkg::*;
  import pixelPkg::*;

  localparam int unsigned pixelBits = $bits(rgb565T);

  ciOpT                          s_decodedOp;
  ciOpT                          s_opReg;
  ciWordT                        s_swapWordReg;
  logic                          s_grayIssued;
  logic [2*`OR1420_WORD_WIDTH-1:0] s_pixelWords;

  // unknown numbers decode to none and never complete
  always_comb begin
    s_decodedOp = CI_OP_NONE;
    if (ciStart) begin
      if (ciN == `OR1420_CI_SWAP_ID) begin
        s_decodedOp = CI_OP_SWAP;
      end else if (ciN == `OR1420_CI_GRAY_ID) begin
        s_decodedOp = CI_OP_GRAY;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge coreReady) begin
    if (!coreReady) begin
      s_opReg <= CI_OP_NONE;
    end else begin
      s_opReg <= s_decodedOp;
    end
  end

  // byte 0 to byte 3, byte 1 to byte 2
  always_ff @(posedge s_systemClock) begin
    if (s_decodedOp == CI_OP_SWAP) begin
      s_swapWordReg <= {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  assign swapValid    = (s_opReg == CI_OP_SWAP);
  assign swapWord     = s_swapWordReg;
  assign s_grayIssued = (s_opReg == CI_OP_GRAY);

  // pixels 0,1 from operand a and 2,3 from operand b
  assign s_pixelWords = {ciDataB, ciDataA};

  for (genvar i = 0; i < `OR1420_NUM_LANES; i++) begin : gLaneFeed
    rgb565T s_pixelReg;

    always_ff @(posedge s_systemClock) begin
      if (s_decodedOp == CI_OP_GRAY) begin
        s_pixelReg <= rgb565T'(s_pixelWords[i*pixelBits +: pixelBits]);
      end
    end

    assign lanes[i].pixel      = s_pixelReg;
    assign lanes[i].pixelValid = s_grayIssued;
  end

endmodule

/* grayLane.sv */
`include "or1420Ci_defines.svh"

module grayLane (
  input logic      s_systemClock,
  input logic      coreReady,
  pixelLaneIf.lane lane
);
  import pixelPkg::*;

  logic [7:0]  s_red;
  logic [7:0]  s_green;
  logic [7:0]  s_blue;
  logic [15:0] s_weightedSum;
  logic        s_grayValidReg;
  grayT        s_grayReg;

  // widen to 8 bits by zero fill
  assign s_red   = {lane.pixel.red, 3'b000};
  assign s_green = {lane.pixel.green, 2'b00};
  assign s_blue  = {lane.pixel.blue, 3'b000};

  // worst case stays below 2**16
  assign s_weightedSum = 16'(`OR1420_RED_WEIGHT) * 16'(s_red) +
                         16'(`OR1420_GREEN_WEIGHT) * 16'(s_green) +
                         16'(`OR1420_BLUE_WEIGHT) * 16'(s_blue);

  always_ff @(posedge s_systemClock or negedge coreReady) begin
    if (!coreReady) begin
      s_grayValidReg <= 1'b0;
    end else begin
      s_grayValidReg <= lane.pixelValid;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (lane.pixelValid) begin
      s_grayReg <= s_weightedSum[15:8];
    end
  end

  assign lane.grayValid = s_grayValidReg;
  assign lane.gray      = s_grayReg;

  assert property (@(posedge s_systemClock) disable iff (!coreReady)
    lane.grayValid == $past(lane.pixelValid));

endmodule

/* ciCollect.sv */
`include "or1420Ci_defines.svh"

module ciCollect (
  input  logic           s_systemClock,
  input  logic           coreReady,
  pixelLaneIf.collect    lanes [`OR1420_NUM_LANES],
  input  logic           swapValid,
  input  ciPkg::ciWordT  swapWord,
  output logic           ciDone,
  output ciPkg::ciWordT  ciResult
);
  import ciPkg::*;
  import pixelPkg::*;

  logic                               s_swapDoneReg;
  ciWordT                             s_swapResultReg;
  logic [`OR1420_NUM_LANES-1:0]       s_grayValids;
  grayT [`OR1420_NUM_LANES-1:0]       s_grayBytes;
  logic                               s_grayDone;
  ciWordT                             s_grayResult;
  ciWordT                             s_swapResult;

  // swap gets one extra stage to line up with the lanes
  always_ff @(posedge s_systemClock or negedge coreReady) begin
    if (!coreReady) begin
      s_swapDoneReg <= 1'b0;
    end else begin
      s_swapDoneReg <= swapValid;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (swapValid) begin
      s_swapResultReg <= swapWord;
    end
  end

  // gray byte k goes to result byte k
  for (genvar i = 0; i < `OR1420_NUM_LANES; i++) begin : gLaneDrain
    assign s_grayValids[i] = lanes[i].grayValid;
    assign s_grayBytes[i]  = lanes[i].gray;
  end

  // all lanes are fed together
  assign s_grayDone   = &s_grayValids;
  assign s_grayResult = s_grayDone ? ciWordT'(s_grayBytes) : '0;
  assign s_swapResult = s_swapDoneReg ? s_swapResultReg : '0;

  // same or-merge as on the cpu side
  assign ciDone   = s_grayDone | s_swapDoneReg;
  assign ciResult = s_grayResult | s_swapResult;

  // one op per start, so the two paths can never finish together
  assert property (@(posedge s_systemClock) disable iff (!coreReady)
    !(s_grayDone && s_swapDoneReg));

endmodule

/* or1420CiTop.sv */
`include "or1420Ci_defines.svh"

module or1420CiTop (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  logic            ciStart,
  input  ciPkg::ciNumberT ciN,
  input  ciPkg::ciWordT   ciDataA,
  input  ciPkg::ciWordT   ciDataB,
  output logic            ciDone,
  output ciPkg::ciWordT   ciResult,
  output logic            coreReady
);
  import ciPkg::*;

  logic   s_swapValid;
  ciWordT s_swapWord;

  pixelLaneIf s_laneIf [`OR1420_NUM_LANES] ();

  resetSequencer resetSequencerInst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .coreReady     (coreReady)
  );

  ciDispatch ciDispatchInst (
    .s_systemClock (s_systemClock),
    .coreReady     (coreReady),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .lanes         (s_laneIf),
    .swapValid     (s_swapValid),
    .swapWord      (s_swapWord)
  );

  // one converter per pixel
  for (genvar i = 0; i < `OR1420_NUM_LANES; i++) begin : gGrayLane
    grayLane grayLaneInst (
      .s_systemClock (s_systemClock),
      .coreReady     (coreReady),
      .lane          (s_laneIf[i])
    );
  end

  ciCollect ciCollectInst (
    .s_systemClock (s_systemClock),
    .coreReady     (coreReady),
    .lanes         (s_laneIf),
    .swapValid     (s_swapValid),
    .swapWord      (s_swapWord),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

/* tbOr1420Ci.sv */
`include "or1420Ci_defines.svh"

module tbOr1420Ci;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned readyDelay  = 16;
  localparam int unsigned preReadyOps = 5 + readyDelay;
  localparam int unsigned numSwaps    = 200;
  localparam int unsigned numGrays    = 200;
  localparam int unsigned numCorners  = 2;
  localparam int unsigned numMixed    = 100;
  localparam int unsigned numUnknown  = 100;
  localparam int unsigned numOps      = preReadyOps + numSwaps + numGrays + numCorners +
                                        numMixed + numUnknown;
  localparam int unsigned cycleLimit  = numOps + 64;

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        s_ciStart;
  logic [7:0]  s_ciN;
  logic [31:0] s_ciDataA;
  logic [31:0] s_ciDataB;
  logic        s_ciDone;
  logic [31:0] s_ciResult;
  logic        s_coreReady;

  int unsigned cycle;
  int unsigned lockCycle;
  logic        locked;
  logic [31:0] lfsrState;
  string       phaseName;

  // expected completions in issue order
  int unsigned expectedDue[$];
  logic [31:0] expectedValue[$];
  string       expectedName[$];

  or1420CiTop dut_i (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (s_ciStart),
    .ciN           (s_ciN),
    .ciDataA       (s_ciDataA),
    .ciDataB       (s_ciDataB),
    .ciDone        (s_ciDone),
    .ciResult      (s_ciResult),
    .coreReady     (s_coreReady)
  );

  always #5 s_systemClock = ~s_systemClock;

  // galois form with one shift per bit handed out
  function automatic logic [31:0] takeBits(input int unsigned count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      outBit = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
      end
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  function automatic logic modelReady();
    return locked && (cycle >= lockCycle + readyDelay);
  endfunction

  // byte k of the operand lands in byte 3-k of the result
  function automatic logic [31:0] swapModel(input logic [31:0] word);
    logic [31:0] swapped;
    for (int k = 0; k < 4; k++) begin
      swapped[8*(3-k) +: 8] = word[8*k +: 8];
    end
    return swapped;
  endfunction

  // 54 R + 183 G + 19 B over 256 with fields zero filled to 8 bits
  function automatic logic [7:0] grayOfPixel(input logic [15:0] pixel);
    logic [17:0] red8;
    logic [17:0] green8;
    logic [17:0] blue8;
    logic [17:0] weighted;
    red8     = {10'd0, pixel[15:11], 3'b000};
    green8   = {10'd0, pixel[10:5], 2'b00};
    blue8    = {10'd0, pixel[4:0], 3'b000};
    weighted = 18'd54 * red8 + 18'd183 * green8 + 18'd19 * blue8;
    return weighted[15:8];
  endfunction

  function automatic logic [31:0] grayModel(input logic [31:0] dataA, input logic [31:0] dataB);
    return {grayOfPixel(dataB[31:16]), grayOfPixel(dataB[15:0]),
            grayOfPixel(dataA[31:16]), grayOfPixel(dataA[15:0])};
  endfunction

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %08h actual %08h", testName, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one op per cycle driven just after the edge
  task automatic driveOp(input logic start, input logic [7:0] number,
                         input logic [31:0] dataA, input logic [31:0] dataB, input string name);
    @(posedge s_systemClock);
    #1;
    phaseName = name;
    s_ciStart = start;
    s_ciN     = number;
    s_ciDataA = dataA;
    s_ciDataB = dataB;
    if (start && modelReady()) begin
      if (number == `OR1420_CI_SWAP_ID) begin
        expectedDue.push_back(cycle + 2);
        expectedValue.push_back(swapModel(dataA));
        expectedName.push_back({name, " swap"});
      end else if (number == `OR1420_CI_GRAY_ID) begin
        expectedDue.push_back(cycle + 2);
        expectedValue.push_back(grayModel(dataA, dataB));
        expectedName.push_back({name, " gray"});
      end
    end
  endtask

  task automatic issueSwap(input string name);
    logic [31:0] dataA;
    logic [31:0] dataB;
    dataA = takeBits(32);
    dataB = takeBits(32);
    driveOp(1'b1, `OR1420_CI_SWAP_ID, dataA, dataB, name);
  endtask

  task automatic issueGray(input string name);
    logic [31:0] dataA;
    logic [31:0] dataB;
    dataA = takeBits(32);
    dataB = takeBits(32);
    driveOp(1'b1, `OR1420_CI_GRAY_ID, dataA, dataB, name);
  endtask

  task automatic issueRandomKnown(input string name);
    logic [31:0] select;
    select = takeBits(1);
    if (select[0]) begin
      issueSwap(name);
    end else begin
      issueGray(name);
    end
  endtask

  // either a start with an unused number or a known number without start
  task automatic issueUnknown(input string name);
    logic [31:0] select;
    logic [31:0] bits;
    logic [7:0]  number;
    select = takeBits(1);
    if (select[0]) begin
      bits   = takeBits(8);
      number = bits[7:0];
      while (number == `OR1420_CI_SWAP_ID || number == `OR1420_CI_GRAY_ID) begin
        bits   = takeBits(8);
        number = bits[7:0];
      end
      driveOp(1'b1, number, takeBits(32), takeBits(32), name);
    end else begin
      bits   = takeBits(1);
      number = bits[0] ? `OR1420_CI_SWAP_ID : `OR1420_CI_GRAY_ID;
      driveOp(1'b0, number, takeBits(32), takeBits(32), name);
    end
  endtask

  task automatic waitDrained(input string name);
    while (expectedDue.size() != 0) begin
      driveOp(1'b0, 8'd0, 32'd0, 32'd0, name);
    end
  endtask

  always @(posedge s_systemClock) begin
    cycle <= cycle + 1;
    if (cycle >= cycleLimit) begin
      $display("timeout: run went past %0d cycles", cycleLimit);
      $display("Test FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  // outputs settle well before the falling edge
  always @(negedge s_systemClock) begin
    checkValue({phaseName, " coreReady"}, {31'd0, modelReady()}, {31'd0, s_coreReady});
    if (expectedDue.size() != 0 && expectedDue[0] == cycle) begin
      checkValue({expectedName[0], " done"}, 32'd1, {31'd0, s_ciDone});
      checkValue({expectedName[0], " result"}, expectedValue[0], s_ciResult);
      void'(expectedDue.pop_front());
      void'(expectedValue.pop_front());
      void'(expectedName.pop_front());
    end else begin
      checkValue({phaseName, " idle done"}, 32'd0, {31'd0, s_ciDone});
      checkValue({phaseName, " idle result"}, 32'd0, s_ciResult);
    end
  end

  initial begin
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    s_ciStart     = 1'b0;
    s_ciN         = 8'd0;
    s_ciDataA     = 32'd0;
    s_ciDataB     = 32'd0;
    cycle         = 0;
    lockCycle     = 0;
    locked        = 1'b0;
    lfsrState     = 32'h1e9c_d652;
    phaseName     = "reset";

    // starts while the pll is not locked and while the core is held
    repeat (5) issueRandomKnown("reset");
    s_pllLocked = 1'b1;
    lockCycle   = cycle;
    locked      = 1'b1;
    while (!modelReady()) begin
      issueRandomKnown("reset");
    end
    waitDrained("reset");

    repeat (numSwaps) issueSwap("swap");
    waitDrained("swap");

    repeat (numGrays) issueGray("gray");
    driveOp(1'b1, `OR1420_CI_GRAY_ID, 32'h0000_0000, 32'h0000_0000, "gray zero");
    driveOp(1'b1, `OR1420_CI_GRAY_ID, 32'hffff_ffff, 32'hffff_ffff, "gray ones");
    waitDrained("gray");

    repeat (numMixed) issueRandomKnown("mixed");
    waitDrained("mixed");

    repeat (numUnknown) issueUnknown("unknown");
    waitDrained("unknown");
    repeat (4) driveOp(1'b0, 8'd0, 32'd0, 32'd0, "idle");

    $display("Test OK");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
ciPkg.sv
pixelPkg.sv
pixelLaneIf.sv
resetSequencer.sv
ciDispatch.sv
grayLane.sv
ciCollect.sv
or1420CiTop.sv
tbOr1420Ci.sv

/* Makefile */
TOP := tbOr1420Ci

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
